// File: Bender.yml
package:
  name: ip_rx

sources:
  - files:
      - common/ip_rx_pkg.sv
      - design/ip_payload_align.sv
      - design/ip_hdr_checksum.sv
      - design/ip_rx_ctrl.sv
      - design/ip_payload_skid.sv
      - design/ip_rx_top.sv
  - target: test
    files:
      - bench/tb_ip_rx.sv

// File: all.f
common/ip_rx_pkg.sv
design/ip_payload_align.sv
design/ip_hdr_checksum.sv
design/ip_rx_ctrl.sv
design/ip_payload_skid.sv
design/ip_rx_top.sv
bench/tb_ip_rx.sv

// File: bench/tb_ip_rx.sv
// IP frame receiver testbench
// directed tests over the 64-bit receiver covering reset state, good frames,
// payload lengths, bad header, bad checksum, early end and random back-pressure
module tb_ip_rx;

    // 27 frames of about 37 bytes each times four
    localparam int cycle_limit = 4000;

    logic clk;
    logic rst;
    logic eth_hdr_valid;
    logic eth_hdr_ready;
    ip_rx_pkg::beat_t s_beat;
    logic s_valid;
    logic s_ready;
    ip_rx_pkg::ip_hdr_t ip_hdr;
    logic ip_hdr_valid;
    logic ip_hdr_ready = 1'b1;
    ip_rx_pkg::beat_t m_beat;
    logic m_valid;
    logic m_ready = 1'b1;
    logic busy;
    logic err_hdr_early;
    logic err_bad_hdr;
    logic err_bad_sum;

    logic [31:0] pay_lfsr = 32'h184d;
    logic [31:0] rdy_lfsr = 32'h184d;
    logic rand_ready = 1'b0;
    logic [7:0] tx_bytes[$];
    logic [7:0] pay_bytes[$];
    ip_rx_pkg::ip_hdr_t exp_hdrs[$];
    ip_rx_pkg::beat_t exp_beats[$];
    ip_rx_pkg::ip_hdr_t mon_hdr;
    ip_rx_pkg::beat_t mon_beat;
    ip_rx_pkg::rx_state_e stuck_state;
    int n_hdr_early, n_bad_hdr, n_bad_sum;
    int errors, n_tests, n_failed, cycles;

    ip_rx_top dut (
        .clk           (clk),
        .rst           (rst),
        .eth_hdr_valid (eth_hdr_valid),
        .eth_hdr_ready (eth_hdr_ready),
        .s_beat        (s_beat),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .ip_hdr        (ip_hdr),
        .ip_hdr_valid  (ip_hdr_valid),
        .ip_hdr_ready  (ip_hdr_ready),
        .m_beat        (m_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .busy          (busy),
        .err_hdr_early (err_hdr_early),
        .err_bad_hdr   (err_bad_hdr),
        .err_bad_sum   (err_bad_sum)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], pay_lfsr[0]};
            pay_lfsr = lfsr_next(pay_lfsr);
        end
    endtask

    // ones'-complement sum over the ten header words with the checksum field zeroed
    function automatic ip_rx_pkg::ip_word_t header_sum(input ip_rx_pkg::ip_hdr_t h);
        ip_rx_pkg::ip_hdr_t z;
        logic [31:0] sum;
        z = h;
        z.header_checksum = '0;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'(z[159-16*i -: 16]);
        end
        while (sum[31:16] != 16'd0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    task automatic check_hdr(input string name, input ip_rx_pkg::ip_hdr_t got,
                             input ip_rx_pkg::ip_hdr_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_beat(input string name, input ip_rx_pkg::beat_t got,
                              input ip_rx_pkg::beat_t exp);
        ip_rx_pkg::data_t mask;
        for (int j = 0; j < ip_rx_pkg::keep_w; j++) begin
            mask[8*j +: 8] = {8{exp.keep[j]}};
        end
        if (got.keep !== exp.keep || got.last !== exp.last ||
            (got.data & mask) !== (exp.data & mask)) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // header in wire order followed by random payload bytes
    task automatic make_frame(input int pay_len, input logic [3:0] version,
                              input logic [3:0] ihl, input logic flip_sum,
                              output ip_rx_pkg::ip_hdr_t h);
        ip_rx_pkg::ip_hdr_t b;
        logic [31:0] r;
        b = '0;
        b.version = version;
        b.ihl = ihl;
        b.length = 16'(20 + pay_len);
        take_bits(16, r);
        b.identification = r[15:0];
        b.flags = 3'b010;
        b.ttl = 8'd64;
        b.protocol = 8'd17;
        take_bits(32, r);
        b.source_ip = r;
        take_bits(32, r);
        b.dest_ip = r;
        b.header_checksum = header_sum(b);
        if (flip_sum) begin
            b.header_checksum[3] = ~b.header_checksum[3];
        end
        tx_bytes.delete();
        pay_bytes.delete();
        for (int i = 0; i < 20; i++) begin
            tx_bytes.push_back(b[159-8*i -: 8]);
        end
        for (int i = 0; i < pay_len; i++) begin
            take_bits(8, r);
            tx_bytes.push_back(r[7:0]);
            pay_bytes.push_back(r[7:0]);
        end
        h = b;
    endtask

    // payload leaves in whole words and the last one keeps its low bytes
    task automatic expect_frame(input ip_rx_pkg::ip_hdr_t h);
        ip_rx_pkg::beat_t b;
        int n;
        exp_hdrs.push_back(h);
        b = '0;
        n = 0;
        for (int i = 0; i < pay_bytes.size(); i++) begin
            b.data[8*n +: 8] = pay_bytes[i];
            b.keep[n] = 1'b1;
            n++;
            if (n == 8 || i == pay_bytes.size() - 1) begin
                b.last = (i == pay_bytes.size() - 1);
                exp_beats.push_back(b);
                b = '0;
                n = 0;
            end
        end
    endtask

    task automatic wait_ready(input logic on_eth);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = on_eth ? eth_hdr_ready : s_ready;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_frame(input int n_bytes);
        ip_rx_pkg::beat_t b;
        int n_beats;
        eth_hdr_valid = 1'b1;
        wait_ready(1'b1);
        eth_hdr_valid = 1'b0;
        n_beats = (n_bytes + 7) / 8;
        for (int k = 0; k < n_beats; k++) begin
            b = '0;
            for (int j = 0; j < 8; j++) begin
                if (8 * k + j < n_bytes) begin
                    b.data[8*j +: 8] = tx_bytes[8*k+j];
                    b.keep[j] = 1'b1;
                end
            end
            b.last = (k == n_beats - 1);
            s_beat = b;
            s_valid = 1'b1;
            wait_ready(1'b0);
        end
        s_valid = 1'b0;
        s_beat = '0;
    endtask

    // ready for the next frame and the output stage empty
    task automatic wait_idle;
        @(negedge clk);
        while (!eth_hdr_ready || m_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic check_done(input int hdr_early, input int bad_hdr, input int bad_sum);
        check_count("err_hdr_early pulses", n_hdr_early, hdr_early);
        check_count("err_bad_hdr pulses", n_bad_hdr, bad_hdr);
        check_count("err_bad_sum pulses", n_bad_sum, bad_sum);
        check_count("headers not received", exp_hdrs.size(), 0);
        check_count("payload beats not received", exp_beats.size(), 0);
        check_bit("busy", busy, 1'b0);
        exp_hdrs.delete();
        exp_beats.delete();
        n_hdr_early = 0;
        n_bad_hdr = 0;
        n_bad_sum = 0;
    endtask

    // send_len below the full length cuts the frame short
    task automatic run_frame(input int pay_len, input logic [3:0] version,
                             input logic [3:0] ihl, input logic flip_sum,
                             input int send_len);
        ip_rx_pkg::ip_hdr_t h;
        logic early, hdr_bad;
        make_frame(pay_len, version, ihl, flip_sum, h);
        early = (send_len <= 16);
        hdr_bad = (version != ip_rx_pkg::ip_version_v4) || (ihl != ip_rx_pkg::ip_ihl_min);
        if (!early && !hdr_bad && !flip_sum) begin
            expect_frame(h);
        end
        send_frame(send_len);
        wait_idle();
        check_done(int'(early), int'(!early && hdr_bad), int'(!early && !hdr_bad && flip_sum));
    endtask

    task automatic end_test(input string name, input int errs_before);
        n_tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            n_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // every handshake and status output low while reset is held
    task automatic test_reset_state;
        int e0;
        e0 = errors;
        check_bit("s_ready", s_ready, 1'b0);
        check_bit("eth_hdr_ready", eth_hdr_ready, 1'b0);
        check_bit("ip_hdr_valid", ip_hdr_valid, 1'b0);
        check_bit("m_valid", m_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("err_hdr_early", err_hdr_early, 1'b0);
        check_bit("err_bad_hdr", err_bad_hdr, 1'b0);
        check_bit("err_bad_sum", err_bad_sum, 1'b0);
        end_test("reset_state", e0);
    endtask

    task automatic test_good_frame;
        int e0;
        e0 = errors;
        run_frame(24, ip_rx_pkg::ip_version_v4, ip_rx_pkg::ip_ihl_min, 1'b0, 44);
        end_test("good_frame", e0);
    endtask

    task automatic test_payload_lengths;
        int e0;
        e0 = errors;
        for (int n = 1; n <= 17; n++) begin
            run_frame(n, ip_rx_pkg::ip_version_v4, ip_rx_pkg::ip_ihl_min, 1'b0, 20 + n);
        end
        end_test("payload_lengths", e0);
    endtask

    task automatic test_bad_header;
        int e0;
        e0 = errors;
        run_frame(12, 4'd6, ip_rx_pkg::ip_ihl_min, 1'b0, 32);
        run_frame(12, ip_rx_pkg::ip_version_v4, 4'd6, 1'b0, 32);
        run_frame(9, ip_rx_pkg::ip_version_v4, ip_rx_pkg::ip_ihl_min, 1'b0, 29);
        end_test("bad_header", e0);
    endtask

    task automatic test_bad_checksum;
        int e0;
        e0 = errors;
        run_frame(12, ip_rx_pkg::ip_version_v4, ip_rx_pkg::ip_ihl_min, 1'b1, 32);
        run_frame(15, ip_rx_pkg::ip_version_v4, ip_rx_pkg::ip_ihl_min, 1'b0, 35);
        end_test("bad_checksum", e0);
    endtask

    task automatic test_hdr_early;
        int e0;
        e0 = errors;
        // input last lands in beat 1
        run_frame(12, ip_rx_pkg::ip_version_v4, ip_rx_pkg::ip_ihl_min, 1'b0, 14);
        end_test("hdr_early", e0);
    endtask

    task automatic test_backpressure;
        ip_rx_pkg::ip_hdr_t h;
        int e0;
        e0 = errors;
        @(negedge clk);
        rand_ready = 1'b1;
        @(posedge clk);
        #2;
        for (int f = 0; f < 3; f++) begin
            make_frame(7 + 9 * f, ip_rx_pkg::ip_version_v4, ip_rx_pkg::ip_ihl_min, 1'b0, h);
            expect_frame(h);
            send_frame(27 + 9 * f);
        end
        wait_idle();
        check_done(0, 0, 0);
        @(negedge clk);
        rand_ready = 1'b0;
        @(posedge clk);
        #2;
        end_test("backpressure", e0);
    endtask

    always @(posedge clk) begin
        #2;
        if (rand_ready) begin
            m_ready = rdy_lfsr[0];
            rdy_lfsr = lfsr_next(rdy_lfsr);
            ip_hdr_ready = rdy_lfsr[0];
            rdy_lfsr = lfsr_next(rdy_lfsr);
        end else begin
            m_ready = 1'b1;
            ip_hdr_ready = 1'b1;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (ip_hdr_valid && ip_hdr_ready) begin
                if (exp_hdrs.size() == 0) begin
                    errors++;
                    $display("error at %0t: ip header received with none expected", $time);
                end else begin
                    mon_hdr = exp_hdrs.pop_front();
                    check_hdr("ip_hdr", ip_hdr, mon_hdr);
                end
            end
            if (m_valid && m_ready) begin
                if (exp_beats.size() == 0) begin
                    errors++;
                    $display("error at %0t: payload beat received with none expected", $time);
                end else begin
                    mon_beat = exp_beats.pop_front();
                    check_beat("m_beat", m_beat, mon_beat);
                end
            end
            n_hdr_early += int'(err_hdr_early);
            n_bad_hdr += int'(err_bad_hdr);
            n_bad_sum += int'(err_bad_sum);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            stuck_state = dut.u_ctrl.state_q;
            $display("run stopped after %0d cycles, controller in %s", cycles, stuck_state.name());
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        eth_hdr_valid = 1'b0;
        s_valid = 1'b0;
        s_beat = '0;
        errors = 0;
        n_tests = 0;
        n_failed = 0;
        cycles = 0;
        n_hdr_early = 0;
        n_bad_hdr = 0;
        n_bad_sum = 0;
        repeat (8) @(posedge clk);
        #2;
        test_reset_state();
        rst = 1'b0;
        test_good_frame();
        test_payload_lengths();
        test_bad_header();
        test_bad_checksum();
        test_hdr_early();
        test_backpressure();
        $display("tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: common/ip_rx_pkg.sv
// IP frame receiver shared definitions
// datapath widths, header field types, the stream beat and the decoded
// IPv4 header structs, and the receive FSM states
package ip_rx_pkg;

    localparam int data_w = 64;
    localparam int keep_w = data_w / 8;

    // header beats on the 64-bit bus (20 header bytes)
    localparam int hdr_beats = 3;

    typedef logic [data_w-1:0] data_t;
    typedef logic [keep_w-1:0] keep_t;
    typedef logic [31:0]       ip_addr_t;
    typedef logic [15:0]       ip_word_t;
    typedef logic [7:0]        ip_byte_t;

    localparam logic [3:0] ip_version_v4 = 4'd4;
    localparam logic [3:0] ip_ihl_min    = 4'd5;

    // one stream beat, keep bit 0 marks the lowest byte
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } beat_t;

    // multi-byte fields hold numeric values, already swapped out of wire order
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        ip_word_t    length;
        ip_word_t    identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        ip_byte_t    ttl;
        ip_byte_t    protocol;
        ip_word_t    header_checksum;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload,
        st_drain
    } rx_state_e;

endpackage

// File: design/ip_hdr_checksum.sv
// IPv4 header checksum unit
// sums the 16-bit words of the three header beats and gives the
// ones'-complement verdict in the cycle after the last header beat
module ip_hdr_checksum (
    input  logic              clk,
    input  logic              rst,
    input  ip_rx_pkg::data_t  data,
    input  logic              take,
    input  logic [1:0]        index,
    output logic              sum_done,
    output logic              sum_ok
);

    localparam logic [1:0] last_idx = 2'(ip_rx_pkg::hdr_beats - 1);

    logic [19:0] part;
    logic [19:0] acc_q;
    logic        done_q;
    logic [16:0] fold;
    logic [15:0] folded;

    always_comb begin
        part = 20'(data[15:0]) + 20'(data[31:16]);
        // last beat only carries header bytes in its lower half
        if (index != last_idx) begin
            part = part + 20'(data[47:32]) + 20'(data[63:48]);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc_q <= (index == 2'd0) ? part : acc_q + part;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= take && (index == last_idx);
        end
    end

    // end-around carry fold
    assign fold     = 17'(acc_q[15:0]) + 17'(acc_q[19:16]);
    assign folded   = fold[15:0] + 16'(fold[16]);
    assign sum_ok   = (folded == 16'hffff);
    assign sum_done = done_q;

endmodule

// File: design/ip_payload_align.sv
// IP payload aligner
// shifts the stream down by four bytes so the payload after the 20-byte
// header starts on a word boundary, and adds a flush beat when the last
// input beat has bytes in its upper half
module ip_payload_align (
    input  logic              clk,
    input  logic              rst,
    input  ip_rx_pkg::beat_t  in_beat,
    input  logic              in_take,
    input  logic              flush,
    output ip_rx_pkg::beat_t  out_beat,
    output logic              out_valid,
    output logic              extra
);

    ip_rx_pkg::beat_t save_q;
    logic             extra_q;

    assign extra = extra_q;

    always_comb begin
        // low half from the saved beat, high half from the current one
        out_beat.data = {in_beat.data[31:0], save_q.data[63:32]};
        out_beat.keep = {in_beat.keep[3:0], save_q.keep[7:4]};
        out_beat.last = in_beat.last && (in_beat.keep[7:4] == 4'd0);
        out_valid     = in_take;

        if (extra_q) begin
            // spill-over of the final input beat
            out_beat.data[63:32] = 32'd0;
            out_beat.keep[7:4]   = 4'd0;
            out_beat.last        = save_q.last;
            out_valid            = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            extra_q <= 1'b0;
        end else if (flush) begin
            extra_q <= 1'b0;
        end else if (in_take) begin
            extra_q <= in_beat.last && (in_beat.keep[7:4] != 4'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (in_take) begin
            save_q <= in_beat;
        end
    end

endmodule

// File: design/ip_payload_skid.sv
// IP payload output stage
// output register with a temp register behind it, so the producer sees a
// registered ready and the stream keeps full rate under back-pressure
module ip_payload_skid (
    input  logic              clk,
    input  logic              rst,
    input  ip_rx_pkg::beat_t  in_beat,
    input  logic              in_valid,
    output logic              ready_early,
    output ip_rx_pkg::beat_t  m_beat,
    output logic              m_valid,
    input  logic              m_ready
);

    ip_rx_pkg::beat_t temp_beat;
    logic temp_valid;
    logic in_ready_q;
    logic m_valid_d, temp_valid_d;
    logic store_out, store_temp, temp_to_out;

    // ready next cycle unless the temp register could fill up
    assign ready_early = m_ready || (!temp_valid && (!m_valid || !in_valid));

    always_comb begin
        m_valid_d    = m_valid;
        temp_valid_d = temp_valid;
        store_out    = 1'b0;
        store_temp   = 1'b0;
        temp_to_out  = 1'b0;

        if (in_ready_q) begin
            if (m_ready || !m_valid) begin
                m_valid_d = in_valid;
                store_out = 1'b1;
            end else begin
                temp_valid_d = in_valid;
                store_temp   = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_d    = temp_valid;
            temp_valid_d = 1'b0;
            temp_to_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
            in_ready_q <= 1'b0;
        end else begin
            m_valid    <= m_valid_d;
            temp_valid <= temp_valid_d;
            in_ready_q <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            m_beat <= in_beat;
        end else if (temp_to_out) begin
            m_beat <= temp_beat;
        end
        if (store_temp) begin
            temp_beat <= in_beat;
        end
    end

endmodule

// File: design/ip_rx_ctrl.sv
// IP receive controller
// frame FSM: takes the Ethernet header strobe, captures the IPv4 header
// from the first three payload beats, checks version, IHL and checksum,
// then forwards the aligned payload or drains the frame
module ip_rx_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                eth_hdr_valid,
    output logic                eth_hdr_ready,
    input  logic                s_valid,
    input  logic                s_last,
    input  ip_rx_pkg::data_t    s_data,
    output logic                s_ready,
    input  ip_rx_pkg::beat_t    al_beat,
    input  logic                al_valid,
    input  logic                al_extra,
    output logic                al_take,
    output logic                al_flush,
    output logic [1:0]          hdr_index,
    output logic                hdr_take,
    input  logic                sum_done,
    input  logic                sum_ok,
    output ip_rx_pkg::ip_hdr_t  ip_hdr,
    output logic                ip_hdr_valid,
    input  logic                ip_hdr_ready,
    output ip_rx_pkg::beat_t    pay_beat,
    output logic                pay_valid,
    input  logic                pay_ready_early,
    output logic                busy,
    output logic                err_hdr_early,
    output logic                err_bad_hdr,
    output logic                err_bad_sum
);

    localparam logic [1:0] last_idx = 2'(ip_rx_pkg::hdr_beats - 1);

    ip_rx_pkg::rx_state_e state_q, state_d;
    ip_rx_pkg::ip_hdr_t   hdr_q;
    logic [1:0] index_q, index_d;
    logic eth_hdr_ready_q, eth_hdr_ready_d;
    logic s_ready_q, s_ready_d;
    logic ip_hdr_valid_q, ip_hdr_valid_d;
    logic hdr_early_d, bad_hdr_d, bad_sum_d;
    logic busy_q, hdr_early_q, bad_hdr_q, bad_sum_q;
    logic out_ready_q;
    logic take;

    assign take          = s_valid && s_ready_q;
    assign al_take       = take;
    assign hdr_take      = take && (state_q == ip_rx_pkg::st_header);
    assign hdr_index     = index_q;
    assign pay_beat      = al_beat;
    assign eth_hdr_ready = eth_hdr_ready_q;
    assign s_ready       = s_ready_q;
    assign ip_hdr        = hdr_q;
    assign ip_hdr_valid  = ip_hdr_valid_q;
    assign busy          = busy_q;
    assign err_hdr_early = hdr_early_q;
    assign err_bad_hdr   = bad_hdr_q;
    assign err_bad_sum   = bad_sum_q;

    always_comb begin
        state_d         = state_q;
        index_d         = index_q;
        eth_hdr_ready_d = 1'b0;
        s_ready_d       = s_ready_q;
        ip_hdr_valid_d  = ip_hdr_valid_q && !ip_hdr_ready;
        hdr_early_d     = 1'b0;
        bad_hdr_d       = 1'b0;
        bad_sum_d       = 1'b0;
        pay_valid       = 1'b0;
        al_flush        = 1'b0;

        case (state_q)
            ip_rx_pkg::st_idle: begin
                al_flush  = 1'b1;
                index_d   = 2'd0;
                s_ready_d = 1'b0;
                // hold off the next frame while a header is still waiting
                eth_hdr_ready_d = !ip_hdr_valid_d;
                if (eth_hdr_valid && eth_hdr_ready_q) begin
                    eth_hdr_ready_d = 1'b0;
                    s_ready_d       = 1'b1;
                    state_d         = ip_rx_pkg::st_header;
                end
            end
            ip_rx_pkg::st_header: begin
                if (take) begin
                    index_d = index_q + 2'd1;
                    // beat 2 may end the frame if it carries payload bytes
                    if ((index_q != last_idx) ? s_last : al_beat.last) begin
                        hdr_early_d = 1'b1;
                        s_ready_d   = 1'b0;
                        state_d     = ip_rx_pkg::st_idle;
                    end else if (index_q == last_idx) begin
                        if (hdr_q.version != ip_rx_pkg::ip_version_v4 ||
                            hdr_q.ihl != ip_rx_pkg::ip_ihl_min) begin
                            bad_hdr_d = 1'b1;
                            s_ready_d = !s_last;
                            state_d   = s_last ? ip_rx_pkg::st_idle : ip_rx_pkg::st_drain;
                        end else begin
                            // payload waits for the checksum verdict
                            s_ready_d = 1'b0;
                            state_d   = ip_rx_pkg::st_payload;
                        end
                    end
                end
            end
            ip_rx_pkg::st_payload: begin
                if (sum_done) begin
                    if (sum_ok) begin
                        ip_hdr_valid_d = 1'b1;
                        s_ready_d      = pay_ready_early && !al_extra;
                    end else begin
                        // a pending flush beat means the input last is already in
                        bad_sum_d = 1'b1;
                        s_ready_d = !al_extra;
                        state_d   = al_extra ? ip_rx_pkg::st_idle : ip_rx_pkg::st_drain;
                    end
                end else begin
                    pay_valid = al_valid && out_ready_q;
                    s_ready_d = pay_ready_early && !al_extra && !(take && s_last);
                    if (pay_valid && al_beat.last) begin
                        state_d = ip_rx_pkg::st_idle;
                    end
                end
            end
            ip_rx_pkg::st_drain: begin
                if (take && s_last) begin
                    s_ready_d = 1'b0;
                    state_d   = ip_rx_pkg::st_idle;
                end
            end
            default: begin
                state_d = ip_rx_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= ip_rx_pkg::st_idle;
            index_q         <= 2'd0;
            eth_hdr_ready_q <= 1'b0;
            s_ready_q       <= 1'b0;
            ip_hdr_valid_q  <= 1'b0;
            out_ready_q     <= 1'b0;
            busy_q          <= 1'b0;
            hdr_early_q     <= 1'b0;
            bad_hdr_q       <= 1'b0;
            bad_sum_q       <= 1'b0;
        end else begin
            state_q         <= state_d;
            index_q         <= index_d;
            eth_hdr_ready_q <= eth_hdr_ready_d;
            s_ready_q       <= s_ready_d;
            ip_hdr_valid_q  <= ip_hdr_valid_d;
            // mirrors the input-ready register inside the skid stage
            out_ready_q     <= pay_ready_early;
            busy_q          <= (state_d != ip_rx_pkg::st_idle);
            hdr_early_q     <= hdr_early_d;
            bad_hdr_q       <= bad_hdr_d;
            bad_sum_q       <= bad_sum_d;
        end
    end

    // header fields arrive in network byte order
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            case (index_q)
                2'd0: begin
                    {hdr_q.version, hdr_q.ihl} <= s_data[7:0];
                    {hdr_q.dscp, hdr_q.ecn}    <= s_data[15:8];
                    hdr_q.length               <= {s_data[23:16], s_data[31:24]};
                    hdr_q.identification       <= {s_data[39:32], s_data[47:40]};
                    {hdr_q.flags, hdr_q.fragment_offset} <= {s_data[55:48], s_data[63:56]};
                end
                2'd1: begin
                    hdr_q.ttl             <= s_data[7:0];
                    hdr_q.protocol        <= s_data[15:8];
                    hdr_q.header_checksum <= {s_data[23:16], s_data[31:24]};
                    hdr_q.source_ip       <= {s_data[39:32], s_data[47:40],
                                              s_data[55:48], s_data[63:56]};
                end
                default: begin
                    hdr_q.dest_ip <= {s_data[7:0], s_data[15:8],
                                      s_data[23:16], s_data[31:24]};
                end
            endcase
        end
    end

endmodule

// File: design/ip_rx_top.sv
// IP frame receiver, 64-bit datapath
// Ethernet header strobe and payload stream in, decoded IPv4 header and
// word-aligned IP payload out, with busy and error status
module ip_rx_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                eth_hdr_valid,
    output logic                eth_hdr_ready,
    input  ip_rx_pkg::beat_t    s_beat,
    input  logic                s_valid,
    output logic                s_ready,
    output ip_rx_pkg::ip_hdr_t  ip_hdr,
    output logic                ip_hdr_valid,
    input  logic                ip_hdr_ready,
    output ip_rx_pkg::beat_t    m_beat,
    output logic                m_valid,
    input  logic                m_ready,
    output logic                busy,
    output logic                err_hdr_early,
    output logic                err_bad_hdr,
    output logic                err_bad_sum
);

    ip_rx_pkg::beat_t al_beat;
    ip_rx_pkg::beat_t pay_beat;
    logic       al_valid, al_extra, al_take, al_flush;
    logic [1:0] hdr_index;
    logic       hdr_take, sum_done, sum_ok;
    logic       pay_valid, pay_ready_early;

    ip_payload_align u_align (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (s_beat),
        .in_take   (al_take),
        .flush     (al_flush),
        .out_beat  (al_beat),
        .out_valid (al_valid),
        .extra     (al_extra)
    );

    ip_hdr_checksum u_checksum (
        .clk      (clk),
        .rst      (rst),
        .data     (s_beat.data),
        .take     (hdr_take),
        .index    (hdr_index),
        .sum_done (sum_done),
        .sum_ok   (sum_ok)
    );

    ip_rx_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .eth_hdr_valid   (eth_hdr_valid),
        .eth_hdr_ready   (eth_hdr_ready),
        .s_valid         (s_valid),
        .s_last          (s_beat.last),
        .s_data          (s_beat.data),
        .s_ready         (s_ready),
        .al_beat         (al_beat),
        .al_valid        (al_valid),
        .al_extra        (al_extra),
        .al_take         (al_take),
        .al_flush        (al_flush),
        .hdr_index       (hdr_index),
        .hdr_take        (hdr_take),
        .sum_done        (sum_done),
        .sum_ok          (sum_ok),
        .ip_hdr          (ip_hdr),
        .ip_hdr_valid    (ip_hdr_valid),
        .ip_hdr_ready    (ip_hdr_ready),
        .pay_beat        (pay_beat),
        .pay_valid       (pay_valid),
        .pay_ready_early (pay_ready_early),
        .busy            (busy),
        .err_hdr_early   (err_hdr_early),
        .err_bad_hdr     (err_bad_hdr),
        .err_bad_sum     (err_bad_sum)
    );

    ip_payload_skid u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (pay_beat),
        .in_valid    (pay_valid),
        .ready_early (pay_ready_early),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule
